// File: rtl/fp_narrow_macros.svh
`ifndef FP_NARROW_MACROS_SVH
`define FP_NARROW_MACROS_SVH

// Binary64 layout
`define FP64_W          64
`define FP64_EXP_W      11
`define FP64_MAN_W      52      // Fraction only, hidden bit not counted
`define FP64_BIAS       1023

// Binary32 layout
`define FP32_W          32
`define FP32_EXP_W      8
`define FP32_MAN_W      23
`define FP32_BIAS       127

// Unbiased exponent limits of binary32
`define FP32_EMAX       127     // Largest normal
`define FP32_EMIN       (-126)  // Smallest normal
`define FP32_DENORM_MIN (-149)  // Weight of the lowest denormal bit

`endif

// File: rtl/fp_narrow_pkg.sv
`include "fp_narrow_macros.svh"

package fp_narrow_pkg;

    // Operand class from the binary64 decode
    typedef enum logic [2:0] {
        ZERO   = 3'd0,
        DENORM = 3'd1,
        NORMAL = 3'd2,
        INF    = 3'd3,
        QNAN   = 3'd4,  // Top fraction bit set
        SNAN   = 3'd5   // Top fraction bit clear, rest nonzero
    } fp_class_t;

    // Exception flags, one set per result
    typedef struct packed {
        logic invalid;    // Signaling NaN seen
        logic overflow;   // Saturated to infinity
        logic underflow;  // Result tiny
        logic inexact;    // Nonzero bits dropped
    } fp_flags_t;

    // Classify output, first pipeline payload
    typedef struct packed {
        logic                  sign;
        fp_class_t             cls;
        logic signed [11:0]    exp;  // Unbiased
        logic [`FP64_MAN_W:0]  sig;  // Hidden bit at the top
    } fp64_fields_t;

    // Converter output, second pipeline payload
    typedef struct packed {
        logic [`FP32_W-1:0] value;
        fp_flags_t          flags;
    } fp32_result_t;

endpackage

// File: rtl/fp64_classify.sv
`timescale 1ns/10ps
`include "fp_narrow_macros.svh"

module fp64_classify (
    input  logic [`FP64_W-1:0]          data,
    output fp_narrow_pkg::fp64_fields_t fields
);

    import fp_narrow_pkg::*;

    logic                   sign;
    logic [`FP64_EXP_W-1:0] exp_b;    // Biased exponent field
    logic [`FP64_MAN_W-1:0] man;      // Fraction field
    logic                   exp_zero;
    logic                   exp_ones;
    logic                   man_zero;
    fp_class_t              cls;

    // Field split
    assign sign  = data[`FP64_W-1];
    assign exp_b = data[`FP64_W-2 -: `FP64_EXP_W];
    assign man   = data[`FP64_MAN_W-1:0];

    assign exp_zero = (exp_b == '0);
    assign exp_ones = (exp_b == '1);
    assign man_zero = (man == '0);

    always_comb begin
        if (exp_zero) begin
            cls = man_zero ? ZERO : DENORM;
        end else if (exp_ones) begin
            if (man_zero)
                cls = INF;
            else if (man[`FP64_MAN_W-1])  // Quiet bit
                cls = QNAN;
            else
                cls = SNAN;
        end else begin
            cls = NORMAL;
        end
    end

    assign fields.sign = sign;
    assign fields.cls  = cls;

    // Denormals share the exponent of the smallest normal
    assign fields.exp = exp_zero ? 12'(1 - `FP64_BIAS)
                                 : 12'($signed({1'b0, exp_b}) - `FP64_BIAS);

    // Hidden bit only on normals
    assign fields.sig = {(!exp_zero && !exp_ones), man};

endmodule

// File: rtl/fp64_to_fp32.sv
`timescale 1ns/10ps
`include "fp_narrow_macros.svh"

module fp64_to_fp32 (
    input  fp_narrow_pkg::fp64_fields_t fields,
    input  logic                        ftz,
    output fp_narrow_pkg::fp32_result_t result
);

    import fp_narrow_pkg::*;

    localparam int DROP = `FP64_MAN_W - `FP32_MAN_W;  // Fraction bits lost, 29

    logic                  is_nan;
    logic [5:0]            dn_shift;   // Right shift for denormal output
    logic [`FP64_MAN_W:0]  dn_sig;
    logic [`FP64_MAN_W:0]  dn_mask;    // Bits that fall off the end
    logic                  dn_lost;
    logic                  nm_lost;

    assign is_nan = (fields.cls == QNAN) || (fields.cls == SNAN);

    // Only meaningful for exponents in [-149, -127], shift 1..23
    assign dn_shift = 6'(`FP32_EMIN - fields.exp);
    assign dn_sig   = fields.sig >> dn_shift;
    assign dn_mask  = ((`FP64_MAN_W+1)'(1) << (dn_shift + DROP)) - 1'b1;
    assign dn_lost  = |(fields.sig & dn_mask);

    assign nm_lost = |fields.sig[DROP-1:0];  // Truncated tail of a normal

    always_comb begin
        result = '0;
        result.value[`FP32_W-1] = fields.sign;  // Sign always kept
        case (fields.cls)
            QNAN, SNAN: begin
                // Quiet bit forced, next 22 fraction bits kept
                result.value[`FP32_W-2:0] = {{`FP32_EXP_W{1'b1}}, 1'b1,
                                             fields.sig[`FP64_MAN_W-2 -: `FP32_MAN_W-1]};
                result.flags.invalid = (fields.cls == SNAN);
            end
            INF: begin
                result.value[`FP32_W-2 -: `FP32_EXP_W] = '1;
            end
            ZERO: begin
                // Signed zero, nothing else to set
            end
            default: begin  // NORMAL and DENORM
                if (fields.exp > `FP32_EMAX) begin
                    result.value[`FP32_W-2 -: `FP32_EXP_W] = '1;  // Saturate to infinity
                    result.flags.overflow = 1'b1;
                    result.flags.inexact  = 1'b1;
                end else if (fields.exp < `FP32_DENORM_MIN) begin
                    // Too small even for a denormal, binary64 denormals land here
                    result.flags.underflow = 1'b1;
                    result.flags.inexact   = 1'b1;
                end else if (fields.exp < `FP32_EMIN) begin
                    if (ftz) begin
                        result.flags.underflow = 1'b1;  // Flushed
                        result.flags.inexact   = 1'b1;
                    end else begin
                        result.value[`FP32_MAN_W-1:0] = dn_sig[DROP +: `FP32_MAN_W];
                        result.flags.underflow = 1'b1;
                        result.flags.inexact   = dn_lost;
                    end
                end else begin
                    // Rebias, truncate fraction
                    result.value[`FP32_W-2 -: `FP32_EXP_W] =
                        `FP32_EXP_W'(fields.exp + `FP32_BIAS);
                    result.value[`FP32_MAN_W-1:0] = fields.sig[`FP64_MAN_W-1 -: `FP32_MAN_W];
                    result.flags.inexact = nm_lost;
                end
            end
        endcase
    end

    // NaN in must come out with an all ones exponent, whatever branch decodes it
    nan_not_finite_a: assert final ($isunknown(fields.cls) || !is_nan ||
                                    result.value[`FP32_W-2 -: `FP32_EXP_W] == '1)
        else $error("NaN input gave finite result %h", result.value);

endmodule

// File: rtl/fp_pipe_stage.sv
`timescale 1ns/10ps

module fp_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid bit, the only control state here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;  // Held otherwise
        end
    end

    // Upstream strobes must stay clean once out of reset
    valid_known_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    ) else $error("out_valid unknown");

endmodule

// File: rtl/fp_flag_regs.sv
`timescale 1ns/10ps

module fp_flag_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_wr,      // Config write strobe
    input  logic                     cfg_ftz,     // New flush-to-zero level
    input  logic                     flag_clear,  // Clear sticky flags
    input  logic                     res_valid,   // Result on the output
    input  fp_narrow_pkg::fp_flags_t res_flags,
    output logic                     ftz,
    output fp_narrow_pkg::fp_flags_t sticky_flags
);

    import fp_narrow_pkg::*;

    fp_flags_t sticky_next;

    // Flush-to-zero setting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ftz <= 1'b0;
        end else if (cfg_wr) begin
            ftz <= cfg_ftz;
        end
    end

    // Clear beats a result landing on the same edge
    always_comb begin
        if (flag_clear)
            sticky_next = '0;
        else if (res_valid)
            sticky_next = sticky_flags | res_flags;  // Accumulate
        else
            sticky_next = sticky_flags;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sticky_flags <= '0;
        end else begin
            sticky_flags <= sticky_next;
        end
    end

    // A clear leaves nothing behind even with a flagged result in the same cycle
    clear_wins_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        flag_clear |=> (sticky_flags == '0)
    ) else $error("sticky_flags %h after clear", sticky_flags);

endmodule

// File: rtl/fp_narrow_top.sv
`timescale 1ns/10ps
`include "fp_narrow_macros.svh"

module fp_narrow_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [`FP64_W-1:0]          in_data,
    input  logic                        cfg_wr,
    input  logic                        cfg_ftz,
    input  logic                        flag_clear,
    output logic                        out_valid,
    output fp_narrow_pkg::fp32_result_t out_result,
    output logic                        ftz,
    output fp_narrow_pkg::fp_flags_t    sticky_flags
);

    import fp_narrow_pkg::*;

    fp64_fields_t cls_fields;  // Classify out, unregistered
    fp64_fields_t s1_fields;   // After first stage
    logic         s1_valid;
    fp32_result_t cvt_result;  // Converter out, unregistered

    fp64_classify u_classify (
        .data   (in_data),
        .fields (cls_fields)
    );

    // Stage 1, decoded operand
    fp_pipe_stage #(.payload_t(fp64_fields_t)) u_stage_fields (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (cls_fields),
        .out_valid (s1_valid),
        .out_data  (s1_fields)
    );

    fp64_to_fp32 u_convert (
        .fields (s1_fields),
        .ftz    (ftz),         // Live setting, applies to whatever sits in stage 1
        .result (cvt_result)
    );

    // Stage 2, result and flags
    fp_pipe_stage #(.payload_t(fp32_result_t)) u_stage_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s1_valid),
        .in_data   (cvt_result),
        .out_valid (out_valid),
        .out_data  (out_result)
    );

    fp_flag_regs u_flag_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_ftz      (cfg_ftz),
        .flag_clear   (flag_clear),
        .res_valid    (out_valid),
        .res_flags    (out_result.flags),
        .ftz          (ftz),
        .sticky_flags (sticky_flags)
    );

endmodule

// File: tb/fp_narrow_ref.svh
`ifndef FP_NARROW_REF_SVH
`define FP_NARROW_REF_SVH

// Expected binary32 value and flags for one binary64 operand
function automatic fp32_result_t narrow_ref(input logic [63:0] d, input logic ftz_on);
    fp32_result_t r;
    logic         sgn;
    logic [10:0]  ef;       // Biased exponent field
    logic [51:0]  fr;       // Fraction field
    int           e;        // Unbiased exponent
    logic [52:0]  sig;      // Significand with hidden bit
    logic [52:0]  lost;
    int           sh;
    r   = '0;
    sgn = d[63];
    ef  = d[62:52];
    fr  = d[51:0];
    e   = int'(ef) - `FP64_BIAS;
    sig = {1'b1, fr};
    r.value[31] = sgn;  // Sign survives every case
    if (ef == 11'h7ff) begin
        if (fr == '0) begin
            r.value[30:23] = 8'hff;  // Infinity
        end else begin
            // Quiet NaN, top 22 of the remaining fraction bits
            r.value[30:0]   = {8'hff, 1'b1, fr[50:29]};
            r.flags.invalid = !fr[51];
        end
    end else if (ef == '0) begin
        if (fr != '0) begin
            r.flags.underflow = 1'b1;  // Binary64 denormal, far below range
            r.flags.inexact   = 1'b1;
        end
    end else if (e > `FP32_EMAX) begin
        r.value[30:23]   = 8'hff;
        r.flags.overflow = 1'b1;
        r.flags.inexact  = 1'b1;
    end else if (e < `FP32_DENORM_MIN) begin
        r.flags.underflow = 1'b1;
        r.flags.inexact   = 1'b1;
    end else if (e < `FP32_EMIN) begin
        r.flags.underflow = 1'b1;
        if (ftz_on) begin
            r.flags.inexact = 1'b1;  // Flushed to signed zero
        end else begin
            // Value in units of the lowest denormal bit is sig * 2^(e - 52 + 149)
            sh   = `FP64_MAN_W - (e - `FP32_DENORM_MIN);
            lost = sig & ((53'd1 << sh) - 53'd1);
            r.value[22:0]   = 23'(sig >> sh);
            r.flags.inexact = (lost != '0);
        end
    end else begin
        r.value[30:23]  = 8'(e + `FP32_BIAS);
        r.value[22:0]   = fr[51:29];  // Truncated
        r.flags.inexact = (fr[28:0] != '0);
    end
    return r;
endfunction

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

task automatic check_result(input fp32_result_t got, input fp32_result_t want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("ERROR out_result: got %h expected %h", got, want);
    end
endtask

task automatic check_flags(input string name, input fp_flags_t got, input fp_flags_t want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("ERROR %s: got %h expected %h", name, got, want);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("ERROR %s: got %h expected %h", name, got, want);
    end
endtask

`endif

// File: tb/fp_narrow_tb.sv
`timescale 1ns/10ps
`include "fp_narrow_macros.svh"

module fp_narrow_tb;

    import fp_narrow_pkg::*;

    // Expected result tagged with its drive cycle
    typedef struct packed {
        fp32_result_t res;
        logic [31:0]  cycle;
    } exp_item_t;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic [`FP64_W-1:0] in_data;
    logic               cfg_wr;
    logic               cfg_ftz;
    logic               flag_clear;
    logic               out_valid;
    fp32_result_t       out_result;
    logic               ftz;
    fp_flags_t          sticky_flags;

    int          errors;
    int          checks;
    logic [31:0] cycle_cnt;
    logic [31:0] lfsr_state;
    logic        ftz_model;   // Setting the next driven item sees
    exp_item_t   exp_q[$];

    `include "fp_narrow_ref.svh"

    fp_narrow_top fp_narrow_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .cfg_wr       (cfg_wr),
        .cfg_ftz      (cfg_ftz),
        .flag_clear   (flag_clear),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .ftz          (ftz),
        .sticky_flags (sticky_flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Pops one expected item per result
    always @(negedge clk) begin : result_checker
        exp_item_t item;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result came out with no item in flight, value %h", out_result);
            end else begin
                item = exp_q.pop_front();
                check_result(out_result, item.res);
                checks++;
                if (cycle_cnt - item.cycle != 32'd2) begin
                    errors++;
                    $display("ERROR out_valid latency: got %h expected %h",
                             cycle_cnt - item.cycle, 32'd2);
                end
            end
        end
    end

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] special_operand(input int idx);
        case (idx)
            0:  return 64'h0000_0000_0000_0000;  // +0
            1:  return 64'h8000_0000_0000_0000;  // -0
            2:  return 64'h7FF0_0000_0000_0000;  // +inf
            3:  return 64'hFFF0_0000_0000_0000;  // -inf
            4:  return 64'h7FF8_0000_0000_0000;  // Quiet NaN
            5:  return 64'hFFFC_DEAD_BEEF_1234;  // Negative quiet NaN with payload
            6:  return 64'h7FF0_0000_0000_0001;  // Signaling NaN whose payload is all dropped
            7:  return 64'hFFF5_5555_AAAA_0000;  // Negative signaling
            8:  return 64'h47EF_FFFF_E000_0000;  // FP32 max exactly
            9:  return 64'h47EF_FFFF_FFFF_FFFF;  // Just above and truncates to max
            10: return 64'h47F0_0000_0000_0000;  // 2^128 is the first overflow
            11: return 64'hC7F0_0000_0000_0000;
            12: return 64'h3FF0_0000_0000_0000;  // 1.0
            default: return 64'h0000_0000_0000_0001;  // Smallest binary64 denormal
        endcase
    endfunction

    function automatic logic [63:0] normal_operand();
        logic [10:0] ef;
        logic        sgn;
        logic [51:0] fr;
        ef  = 11'(`FP32_EMIN + `FP64_BIAS + int'(rand_bits(8) % 254));  // e in [-126, 127]
        sgn = (rand_bits(1) != 0);
        fr  = 52'(rand_bits(52));
        return {sgn, ef, fr};
    endfunction

    function automatic logic [63:0] tiny_operand();
        logic [10:0] ef;
        logic        sgn;
        logic [51:0] fr;
        ef  = 11'(`FP32_DENORM_MIN + `FP64_BIAS + int'(rand_bits(5) % 23));  // e in [-149, -127]
        sgn = (rand_bits(1) != 0);
        fr  = 52'(rand_bits(52));
        return {sgn, ef, fr};
    endfunction

    // Drive one operand for one cycle and queue its expected result
    task automatic send(input logic [63:0] d);
        exp_item_t item;
        item.res   = narrow_ref(d, ftz_model);
        item.cycle = cycle_cnt;
        exp_q.push_back(item);
        in_valid = 1'b1;
        in_data  = d;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timed out with %0d results that never left the pipeline", exp_q.size());
            exp_q.delete();
        end
        @(negedge clk);  // Sticky flags take the last result one edge later
    endtask

    // Only called with the pipeline empty
    task automatic set_ftz(input logic v);
        cfg_wr  = 1'b1;
        cfg_ftz = v;
        @(negedge clk);
        cfg_wr    = 1'b0;
        ftz_model = v;
        check_bit("ftz", ftz, v);
    endtask

    task automatic pulse_clear();
        flag_clear = 1'b1;
        @(negedge clk);
        flag_clear = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before)
            $display("Test %0d %s: ok", num, name);
        else
            $display("Test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    initial begin
        fp_flags_t acc;
        int        err0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        cfg_wr     = 1'b0;
        cfg_ftz    = 1'b0;
        flag_clear = 1'b0;
        errors     = 0;
        checks     = 0;
        cycle_cnt  = '0;
        lfsr_state = 32'he83c;
        ftz_model  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Test 1 with directed specials
        err0 = errors;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("ftz", ftz, 1'b0);
        check_flags("sticky_flags", sticky_flags, '0);
        for (int i = 0; i < 14; i++)
            send(special_operand(i));
        wait_drain();
        report_test(1, "special values", err0);

        // Test 2 sends normal range operands back to back
        err0 = errors;
        for (int i = 0; i < 24; i++)
            send(normal_operand());
        wait_drain();
        report_test(2, "random normal range", err0);

        // Test 3 sends tiny operands without and then with flush-to-zero
        err0 = errors;
        send(64'h36A0_0000_0000_0000);  // 2^-149 is exactly the lowest denormal
        send(64'hB690_0000_0000_0000);  // 2^-150 lies below range
        for (int i = 0; i < 12; i++)
            send(tiny_operand());
        wait_drain();
        set_ftz(1'b1);
        send(64'h36A0_0000_0000_0000);
        for (int i = 0; i < 12; i++)
            send(tiny_operand());
        wait_drain();
        report_test(3, "underflow range", err0);

        // Test 4 on sticky flags
        err0 = errors;
        pulse_clear();
        check_flags("sticky_flags", sticky_flags, '0);
        acc = '0;
        send(special_operand(6));
        acc |= exp_q[$].res.flags;
        send(special_operand(10));
        acc |= exp_q[$].res.flags;
        send(tiny_operand());
        acc |= exp_q[$].res.flags;
        send(normal_operand());
        acc |= exp_q[$].res.flags;
        wait_drain();
        check_flags("sticky_flags", sticky_flags, acc);
        pulse_clear();
        check_flags("sticky_flags", sticky_flags, '0);
        send(special_operand(6));  // Invalid result lands with the clear
        @(negedge clk);
        pulse_clear();
        check_flags("sticky_flags", sticky_flags, '0);
        send(64'h3FF0_0000_0000_0001);  // Inexact only
        acc = exp_q[$].res.flags;
        wait_drain();
        check_flags("sticky_flags", sticky_flags, acc);
        report_test(4, "sticky flags", err0);

        // Test 5 resets with an item in stage 1 and another at the input
        err0 = errors;
        send(special_operand(10));
        wait_drain();
        send(normal_operand());
        in_valid  = 1'b1;
        in_data   = normal_operand();
        rst_n     = 1'b0;
        exp_q.delete();  // Both items are dropped
        ftz_model = 1'b0;
        repeat (3) @(negedge clk);
        in_valid = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("ftz", ftz, 1'b0);
        check_flags("sticky_flags", sticky_flags, '0);
        repeat (4) @(negedge clk);  // Checker flags any stray result here
        send(tiny_operand());
        wait_drain();
        report_test(5, "reset", err0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
+incdir+tb
rtl/fp_narrow_pkg.sv
rtl/fp64_classify.sv
rtl/fp64_to_fp32.sv
rtl/fp_pipe_stage.sv
rtl/fp_flag_regs.sv
rtl/fp_narrow_top.sv
tb/fp_narrow_tb.sv
